//--- design/tiny_core_pkg.sv
// opcodes, function codes, instruction formats, decoded op and commit trace types
package tiny_core_pkg;

  // ----------------------------------------
  // encodings
  // ----------------------------------------

  // primary opcode, top six bits of every word
  typedef enum logic [5:0] {
    op_rtype = 6'h00,
    op_bne   = 6'h05,
    op_addi  = 6'h08,
    op_halt  = 6'h3f
  } opcode_e;

  // r-type function select, low six bits
  typedef enum logic [5:0] {
    f_add = 6'h20,
    f_sub = 6'h22,
    f_and = 6'h24,
    f_or  = 6'h25
  } funct_e;

  // internal alu operation
  typedef enum logic [1:0] {
    alu_add = 2'd0,
    alu_sub = 2'd1,
    alu_and = 2'd2,
    alu_or  = 2'd3
  } alu_op_e;

  // ----------------------------------------
  // instruction word views
  // ----------------------------------------

  // register format
  typedef struct packed {
    opcode_e    opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] unused;
    funct_e     funct;
  } r_fmt_t;

  // immediate format
  // for bne the rd slot holds the second compared register
  typedef struct packed {
    opcode_e            opcode;
    logic        [4:0]  rd;
    logic        [4:0]  rs1;
    logic signed [15:0] imm;
  } i_fmt_t;

  // one word, two decodes
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } inst_u;

  // ----------------------------------------
  // pipeline and trace records
  // ----------------------------------------

  // decode to execute, registered once per cycle
  typedef struct packed {
    logic [31:0] pc;
    alu_op_e     alu_op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic        use_imm;
    logic        is_branch;
    logic        is_halt;
    logic        wen;
    logic        valid;
  } dec_op_t;

  // one commit per val strobe
  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        wen;
    logic        val;
  } trace_t;

endpackage

//--- design/inst_mem.sv
// instruction memory with external load port and combinational fetch read
module inst_mem import tiny_core_pkg::*; #(
  parameter int addr_bits  = 32,
  parameter int imem_depth = 64
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load,
  input  logic [addr_bits-1:0] load_addr,
  input  inst_u                load_data,
  input  logic [addr_bits-1:0] rd_addr,
  output inst_u                rd_data
);

  localparam int idx_bits = (imem_depth > 1) ? $clog2(imem_depth) : 1;

  // program storage
  inst_u mem [imem_depth];

  // fill word for reads past the end
  inst_u halt_word;

  always_comb begin
    halt_word = '0;
    halt_word.i.opcode = op_halt;
  end

  // ----------------------------------------
  // load port
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (load && (load_addr < imem_depth)) begin
      mem[load_addr[idx_bits-1:0]] <= load_data;
    end
  end

  // fetch read, runs off the end into halt
  assign rd_data = (rd_addr < imem_depth) ? mem[rd_addr[idx_bits-1:0]] : halt_word;

  // loader must stay inside the array
  load_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    load |-> (load_addr < imem_depth)
  );

endmodule

//--- design/reg_file.sv
// 32-entry register file, two async reads, one write, r0 reads zero
module reg_file (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        we,
  input  logic [4:0]  wa,
  input  logic [31:0] wd
);

  // r1..r31 only, r0 has no storage
  logic [31:1][31:0] regs;

  // ----------------------------------------
  // write port
  // ----------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regs <= '0;
    end else if (we && (wa != 5'd0)) begin
      regs[wa] <= wd;
    end
  end

  // ----------------------------------------
  // read ports
  // ----------------------------------------

  // reads see the state left by the last commit edge
  // the writer in this cycle is the reader itself
  assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

  // a write aimed at r0 leaves the whole file untouched
  r0_write_dropped: assert property (
    @(posedge clk) disable iff (!rst_n)
    (we && (wa == 5'd0)) |=> $stable(regs)
  );

endmodule

//--- design/decode_unit.sv
// pc sequencing, run control, instruction decode and the fetch pipeline register
module decode_unit import tiny_core_pkg::*; #(
  parameter int addr_bits = 32
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  inst_u                inst,
  output logic [addr_bits-1:0] pc,
  input  logic                 redirect,
  input  logic [addr_bits-1:0] redirect_pc,
  input  logic                 halt,
  output logic                 running,
  output dec_op_t              op
);

  dec_op_t op_d;

  // ----------------------------------------
  // pc and run state
  // ----------------------------------------

  // start wins over anything in flight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc      <= '0;
      running <= 1'b0;
    end else if (start) begin
      pc      <= '0;
      running <= 1'b1;
    end else if (running) begin
      if (halt) begin
        running <= 1'b0;
      end else if (redirect) begin
        pc <= redirect_pc;
      end else begin
        pc <= pc + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // decode
  // ----------------------------------------

  always_comb begin
    op_d         = '0;
    op_d.pc      = 32'(pc);
    op_d.rs1     = inst.i.rs1;
    op_d.imm     = {{16{inst.i.imm[15]}}, inst.i.imm};
    // shadow slot of a redirect or halt is dropped
    op_d.valid   = running && !redirect && !halt;
    case (inst.r.opcode)
      op_rtype: begin
        op_d.rd  = inst.r.rd;
        op_d.rs2 = inst.r.rs2;
        op_d.wen = 1'b1;
        case (inst.r.funct)
          f_sub:   op_d.alu_op = alu_sub;
          f_and:   op_d.alu_op = alu_and;
          f_or:    op_d.alu_op = alu_or;
          default: op_d.alu_op = alu_add;
        endcase
      end
      op_addi: begin
        op_d.rd      = inst.i.rd;
        op_d.alu_op  = alu_add;
        op_d.use_imm = 1'b1;
        op_d.wen     = 1'b1;
      end
      op_bne: begin
        // second compare operand sits in rd
        op_d.rs2       = inst.i.rd;
        op_d.alu_op    = alu_sub;
        op_d.is_branch = 1'b1;
      end
      // halt and any unknown opcode stop the core
      default: op_d.is_halt = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op <= '0;
    end else begin
      op <= op_d;
    end
  end

  // idle core hands nothing to execute
  // running drops on the same edge that squashes the halt shadow
  no_op_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    !running |-> !op.valid
  );

endmodule

//--- design/exec_unit.sv
// alu, bne resolution, register write-back and commit trace
module exec_unit import tiny_core_pkg::*; #(
  parameter int addr_bits = 32
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dec_op_t              op,
  input  logic [31:0]          rs1_data,
  input  logic [31:0]          rs2_data,
  output logic                 we,
  output logic [4:0]           wa,
  output logic [31:0]          wd,
  output logic                 redirect,
  output logic [addr_bits-1:0] redirect_pc,
  output logic                 halt,
  output trace_t               trace
);

  logic [31:0] opnd_b;
  logic [31:0] result;

  // ----------------------------------------
  // alu
  // ----------------------------------------

  // immediate replaces rs2 for addi
  assign opnd_b = op.use_imm ? op.imm : rs2_data;

  always_comb begin
    case (op.alu_op)
      alu_sub: result = rs1_data - opnd_b;
      alu_and: result = rs1_data & opnd_b;
      alu_or:  result = rs1_data | opnd_b;
      default: result = rs1_data + opnd_b;
    endcase
  end

  // ----------------------------------------
  // control flow
  // ----------------------------------------

  // bne taken when the two registers differ
  assign redirect = op.valid && op.is_branch && (rs1_data != rs2_data);

  // offset counts words from the next pc
  assign redirect_pc = op.pc[addr_bits-1:0] + 1'b1 + op.imm[addr_bits-1:0];

  assign halt = op.valid && op.is_halt;

  // ----------------------------------------
  // write-back and trace
  // ----------------------------------------

  assign we = op.valid && op.wen;
  // address and data zeroed on non-writing commits
  assign wa = we ? op.rd : 5'd0;
  assign wd = we ? result : 32'd0;

  always_comb begin
    trace.pc    = op.pc;
    trace.waddr = wa;
    trace.wdata = wd;
    trace.wen   = we;
    trace.val   = op.valid;
  end

  // branch and halt are distinct opcodes, never together
  redirect_halt_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(redirect && halt)
  );

  // nothing commits in the slot after a halt
  quiet_after_halt: assert property (
    @(posedge clk) disable iff (!rst_n)
    halt |=> !op.valid
  );

endmodule

//--- design/tiny_core_top.sv
// core top level tying instruction memory, decode, register file and execute together
module tiny_core_top import tiny_core_pkg::*; #(
  parameter int addr_bits  = 32,
  parameter int imem_depth = 64
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 load,
  input  logic [addr_bits-1:0] load_addr,
  input  inst_u                load_data,
  input  logic                 start,
  output logic                 running,
  output trace_t               trace
);

  // ----------------------------------------
  // internal wires
  // ----------------------------------------

  // fetch side
  logic [addr_bits-1:0] pc;
  inst_u                inst;
  dec_op_t              op;

  // register file ports
  logic [31:0]          rs1_data;
  logic [31:0]          rs2_data;
  logic                 we;
  logic [4:0]           wa;
  logic [31:0]          wd;

  // execute back to fetch
  logic                 redirect;
  logic [addr_bits-1:0] redirect_pc;
  logic                 halt;

  inst_mem #(
    .addr_bits  (addr_bits),
    .imem_depth (imem_depth)
  ) i_inst_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (load),
    .load_addr (load_addr),
    .load_data (load_data),
    .rd_addr   (pc),
    .rd_data   (inst)
  );

  decode_unit #(
    .addr_bits (addr_bits)
  ) i_decode_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .inst        (inst),
    .pc          (pc),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halt        (halt),
    .running     (running),
    .op          (op)
  );

  // sources indexed straight from the registered op
  reg_file i_reg_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (op.rs1),
    .rs2      (op.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (we),
    .wa       (wa),
    .wd       (wd)
  );

  exec_unit #(
    .addr_bits (addr_bits)
  ) i_exec_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .op          (op),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .we          (we),
    .wa          (wa),
    .wd          (wd),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halt        (halt),
    .trace       (trace)
  );

endmodule

//--- dv/trace_checker.sv
// commit trace sink, compare task on trace_t and the running error count
module trace_checker import tiny_core_pkg::*; (
  input logic   clk,
  input trace_t trace
);

  // mismatches found by this sink
  int errors = 0;

  // commits consumed so far
  int commits = 0;

  // ----------------------------------------
  // compare
  // ----------------------------------------

  // pc and wen always, address and data only on writing commits
  task automatic compare_trace(
    input trace_t exp,
    input trace_t act,
    input string  name
  );
    bit bad;
    bad = (act.pc !== exp.pc) || (act.wen !== exp.wen);
    if (exp.wen) begin
      bad = bad || (act.waddr !== exp.waddr) || (act.wdata !== exp.wdata);
    end
    if (bad) begin
      errors++;
      $display("Mismatch %s: expected pc=%0d wen=%0b waddr=%0d wdata=%h",
               name, exp.pc, exp.wen, exp.waddr, exp.wdata);
      $display("Mismatch %s: actual   pc=%0d wen=%0b waddr=%0d wdata=%h",
               name, act.pc, act.wen, act.waddr, act.wdata);
    end
  endtask

  // ----------------------------------------
  // wait for the next commit
  // ----------------------------------------

  // always moves past the current edge first
  // so one commit is never consumed twice
  task automatic check_trace(
    input trace_t exp,
    input string  name
  );
    @(negedge clk);
    while (trace.val !== 1'b1) begin
      @(negedge clk);
    end
    commits++;
    compare_trace(exp, trace, name);
  endtask

  // val itself must never be unknown once out of reset
  always @(negedge clk) begin
    if (commits > 0 && $isunknown(trace.val)) begin
      errors++;
      $display("trace valid strobe went unknown after %0d commits", commits);
    end
  end

endmodule

//--- dv/tb_tiny_core.sv
// testbench top with clock, reset, program loader, isa model, directed tests and summary
module tb_tiny_core import tiny_core_pkg::*;;

  // longest program and margin set the run limit
  localparam int num_tests   = 5;
  localparam int max_words   = 16;
  localparam int cycle_limit = num_tests * max_words * 4 + 500;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        load;
  logic [31:0] load_addr;
  inst_u       load_data;
  logic        start;
  logic        running;
  trace_t      trace;

  integer seed = 23699;
  int     cycles = 0;
  int     tb_errors = 0;
  int     tests_run = 0;
  int     tests_passed = 0;

  // program under test and its predicted commits
  inst_u       prog [$];
  trace_t      expect_q [$];
  logic [31:0] model_regs [32];

  always #4 clk = ~clk;

  tiny_core_top #(
    .addr_bits  (32),
    .imem_depth (64)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (load),
    .load_addr (load_addr),
    .load_data (load_data),
    .start     (start),
    .running   (running),
    .trace     (trace)
  );

  trace_checker i_checker (
    .clk   (clk),
    .trace (trace)
  );

  // ----------------------------------------
  // instruction words
  // ----------------------------------------

  function automatic inst_u rtype_word(funct_e f, logic [4:0] rd, logic [4:0] rs1,
                                       logic [4:0] rs2);
    inst_u w;
    w = '0;
    w.r.opcode = op_rtype;
    w.r.rd = rd;
    w.r.rs1 = rs1;
    w.r.rs2 = rs2;
    w.r.funct = f;
    return w;
  endfunction

  function automatic inst_u addi_word(logic [4:0] rd, logic [4:0] rs1, logic [15:0] imm);
    inst_u w;
    w.i.opcode = op_addi;
    w.i.rd = rd;
    w.i.rs1 = rs1;
    w.i.imm = imm;
    return w;
  endfunction

  // second compared register rides in rd
  function automatic inst_u bne_word(logic [4:0] rs1, logic [4:0] rs2, logic [15:0] imm);
    inst_u w;
    w.i.opcode = op_bne;
    w.i.rd = rs2;
    w.i.rs1 = rs1;
    w.i.imm = imm;
    return w;
  endfunction

  function automatic inst_u halt_word();
    inst_u w;
    w = '0;
    w.i.opcode = op_halt;
    return w;
  endfunction

  // ----------------------------------------
  // isa model
  // ----------------------------------------

  // walks prog from pc 0 until halt, one expected entry per commit
  task automatic predict_trace();
    int          pc;
    int          steps;
    bit          done;
    inst_u       w;
    trace_t      t;
    logic [31:0] a;
    logic [31:0] b;
    expect_q.delete();
    pc = 0;
    steps = 0;
    done = 1'b0;
    while (!done && steps < 256) begin
      w = (pc < prog.size()) ? prog[pc] : halt_word();
      t = '0;
      t.pc = pc;
      t.val = 1'b1;
      a = model_regs[w.i.rs1];
      case (w.i.opcode)
        op_rtype: begin
          b = model_regs[w.r.rs2];
          t.wen = 1'b1;
          t.waddr = w.r.rd;
          case (w.r.funct)
            f_sub:   t.wdata = a - b;
            f_and:   t.wdata = a & b;
            f_or:    t.wdata = a | b;
            default: t.wdata = a + b;
          endcase
          pc++;
        end
        op_addi: begin
          t.wen = 1'b1;
          t.waddr = w.i.rd;
          t.wdata = a + {{16{w.i.imm[15]}}, w.i.imm};
          pc++;
        end
        op_bne: begin
          // offset in words from the following pc
          if (a != model_regs[w.i.rd]) begin
            pc = pc + 1 + int'(w.i.imm);
          end else begin
            pc++;
          end
        end
        default: done = 1'b1;
      endcase
      // r0 writes show in the trace but never stick
      if (t.wen && t.waddr != 5'd0) begin
        model_regs[t.waddr] = t.wdata;
      end
      expect_q.push_back(t);
      steps++;
    end
  endtask

  // ----------------------------------------
  // checks and run flow
  // ----------------------------------------

  task automatic compare_running(input logic exp, input logic act, input string name);
    if (act !== exp) begin
      tb_errors++;
      $display("Mismatch %s: running expected %0b, actual %0b", name, exp, act);
    end
  endtask

  // one load strobe per word, called on a falling edge
  task automatic load_program();
    for (int k = 0; k < prog.size(); k++) begin
      load = 1'b1;
      load_addr = k;
      load_data = prog[k];
      @(negedge clk);
    end
    load = 1'b0;
    load_addr = '0;
    load_data = '0;
  endtask

  task automatic run_program(input string name);
    int errs_before;
    int errs_after;
    errs_before = tb_errors + i_checker.errors;
    load_program();
    predict_trace();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    compare_running(1'b1, running, name);
    foreach (expect_q[k]) begin
      i_checker.check_trace(expect_q[k], name);
    end
    // halt just committed, running drops one cycle later
    @(negedge clk);
    compare_running(1'b0, running, name);
    repeat (10) begin
      @(negedge clk);
      if (trace.val !== 1'b0) begin
        tb_errors++;
        $display("%s: core committed pc %0d after halt", name, trace.pc);
      end
    end
    errs_after = tb_errors + i_checker.errors;
    tests_run++;
    if (errs_after == errs_before) begin
      tests_passed++;
      $display("%-16s ok, %0d commits", name, expect_q.size());
    end else begin
      $display("%-16s failed, %0d errors", name, errs_after - errs_before);
    end
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------

  // dependent chain with no bubbles
  task automatic alu_ops();
    prog.delete();
    prog.push_back(addi_word(5'd1, 5'd0, 16'($random(seed))));
    prog.push_back(addi_word(5'd2, 5'd0, 16'($random(seed))));
    prog.push_back(rtype_word(f_add, 5'd3, 5'd1, 5'd2));
    prog.push_back(rtype_word(f_sub, 5'd4, 5'd3, 5'd1));
    // r4 equals r2 here, so and against r1 to tell and from or
    prog.push_back(rtype_word(f_and, 5'd5, 5'd4, 5'd1));
    prog.push_back(rtype_word(f_or, 5'd6, 5'd5, 5'd1));
    prog.push_back(rtype_word(f_add, 5'd7, 5'd6, 5'd6));
    prog.push_back(halt_word());
    run_program("alu_ops");
  endtask

  task automatic reg_zero();
    prog.delete();
    prog.push_back(addi_word(5'd0, 5'd0, 16'h1234));
    prog.push_back(rtype_word(f_add, 5'd0, 5'd1, 5'd2));
    // r0 read right after an r0 write
    prog.push_back(rtype_word(f_add, 5'd8, 5'd0, 5'd1));
    prog.push_back(halt_word());
    run_program("reg_zero");
  endtask

  // untaken bne, countdown loop, then a taken skip
  task automatic branching();
    logic [15:0] count;
    count = 16'(1 + ($random(seed) & 7));
    prog.delete();
    prog.push_back(addi_word(5'd9, 5'd0, 16'd3));
    prog.push_back(addi_word(5'd10, 5'd0, 16'd3));
    prog.push_back(bne_word(5'd9, 5'd10, 16'd5));
    prog.push_back(addi_word(5'd11, 5'd0, count));
    prog.push_back(addi_word(5'd11, 5'd11, 16'hffff));
    prog.push_back(bne_word(5'd11, 5'd0, -16'sd2));
    prog.push_back(bne_word(5'd9, 5'd11, 16'd1));
    prog.push_back(addi_word(5'd12, 5'd0, 16'h007f));
    prog.push_back(halt_word());
    run_program("branching");
  endtask

  // word past the halt must never commit
  task automatic halt_stop();
    prog.delete();
    prog.push_back(addi_word(5'd13, 5'd0, 16'($random(seed))));
    prog.push_back(halt_word());
    prog.push_back(addi_word(5'd13, 5'd13, 16'd1));
    run_program("halt_stop");
  endtask

  // shorter program over the old one, registers carry over
  task automatic reload_restart();
    prog.delete();
    prog.push_back(rtype_word(f_add, 5'd14, 5'd3, 5'd7));
    prog.push_back(rtype_word(f_sub, 5'd15, 5'd14, 5'd13));
    prog.push_back(rtype_word(f_or, 5'd16, 5'd15, 5'd11));
    prog.push_back(halt_word());
    run_program("reload_restart");
  endtask

  // ----------------------------------------
  // main sequence and timeout
  // ----------------------------------------

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("run stopped after %0d cycles without finishing the tests", cycle_limit);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    rst_n = 1'b0;
    load = 1'b0;
    load_addr = '0;
    load_data = '0;
    start = 1'b0;
    foreach (model_regs[k]) begin
      model_regs[k] = '0;
    end
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    alu_ops();
    reg_zero();
    branching();
    halt_stop();
    reload_restart();
    $display("tests %0d, passed %0d, failed %0d, errors %0d", tests_run, tests_passed,
             tests_run - tests_passed, tb_errors + i_checker.errors);
    if (tb_errors + i_checker.errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- sim.f
design/tiny_core_pkg.sv
design/inst_mem.sv
design/reg_file.sv
design/decode_unit.sv
design/exec_unit.sv
design/tiny_core_top.sv
dv/trace_checker.sv
dv/tb_tiny_core.sv

//--- Bender.yml
package:
  name: tiny_core

sources:
  # core rtl, package first
  - files:
      - design/tiny_core_pkg.sv
      - design/inst_mem.sv
      - design/reg_file.sv
      - design/decode_unit.sv
      - design/exec_unit.sv
      - design/tiny_core_top.sv

  # simulation only
  - target: test
    files:
      - dv/trace_checker.sv
      - dv/tb_tiny_core.sv
